//--- Makefile
# Verilator build and run for the edge detection pipeline

VERILATOR  ?= verilator
TOP        ?= edge_tb
FILE_LIST  ?= project.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing -Wall --timescale 1ns/1ps
PASS_TEXT  ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The run passes only if the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- project.f
verilog/edge_pkg.sv
verilog/fifo.sv
verilog/grayscale.sv
verilog/sobel.sv
verilog/edge_threshold.sv
verilog/edge_top.sv
tb/edge_tb.sv

//--- tb/edge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module edge_tb
    import edge_pkg::*;
();

    localparam int IMAGE_WIDTH    = 16;
    localparam int IMAGE_HEIGHT   = 8;
    localparam int FIFO_DEPTH     = 16;
    localparam int FRAME_PIXELS   = IMAGE_WIDTH * IMAGE_HEIGHT;
    localparam int FRAME_COUNT    = 8;
    localparam int TOTAL_PIXELS   = FRAME_COUNT * FRAME_PIXELS;
    // Last two frames are read with long stalls on the output side
    localparam int PRESSURE_START = 6 * FRAME_PIXELS;
    localparam int TIMEOUT_CYCLES = TOTAL_PIXELS * 4 + 2000;
    localparam int STRETCHES      = 64;

    typedef logic [RGB_BITS-1:0]   rgb_frame_t  [FRAME_PIXELS];
    typedef logic [PIXEL_BITS-1:0] edge_frame_t [FRAME_PIXELS];

    logic                   clock;
    logic                   reset;
    logic                   image_wr_en;
    logic [RGB_BITS-1:0]    image_din;
    logic                   image_full;
    logic                   out_rd_en;
    logic [PIXEL_BITS-1:0]  out_dout;
    logic                   out_empty;
    logic                   frame_done;
    logic [15:0]            edge_count;

    rgb_frame_t             frames [FRAME_COUNT];
    logic [PIXEL_BITS-1:0]  exp_pixels [$];
    int                     exp_counts [$];
    int                     hold_len [STRETCHES];
    int                     run_len [STRETCHES];
    integer                 seed = 85913;
    int                     cycle_count = 0;
    int                     error_count = 0;
    int                     pixels_read = 0;
    int                     frames_seen = 0;
    bit                     saw_full = 1'b0;

    edge_top #(
        .IMAGE_WIDTH(IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) dut (
        .clock(clock),
        .reset(reset),
        .image_wr_en(image_wr_en),
        .image_din(image_din),
        .image_full(image_full),
        .out_rd_en(out_rd_en),
        .out_dout(out_dout),
        .out_empty(out_empty),
        .frame_done(frame_done),
        .edge_count(edge_count)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // Gray mean, Sobel with zero borders, then the double threshold along each row
    function automatic int reference_edges(input rgb_frame_t rgb, output edge_frame_t edges);
        int gray [IMAGE_HEIGHT][IMAGE_WIDTH];
        int gx;
        int gy;
        int mag;
        int count;
        bit prev_on;
        bit on;
        count = 0;
        prev_on = 1'b0;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            gray[i / IMAGE_WIDTH][i % IMAGE_WIDTH] = (int'(rgb[i][RED_LSB +: PIXEL_BITS]) +
                int'(rgb[i][GREEN_LSB +: PIXEL_BITS]) + int'(rgb[i][BLUE_LSB +: PIXEL_BITS])) / 3;
        end
        for (int y = 0; y < IMAGE_HEIGHT; y++) begin
            for (int x = 0; x < IMAGE_WIDTH; x++) begin
                mag = 0;
                if (y > 0 && y < IMAGE_HEIGHT - 1 && x > 0 && x < IMAGE_WIDTH - 1) begin
                    gx = gray[y-1][x+1] + 2 * gray[y][x+1] + gray[y+1][x+1]
                       - gray[y-1][x-1] - 2 * gray[y][x-1] - gray[y+1][x-1];
                    gy = gray[y+1][x-1] + 2 * gray[y+1][x] + gray[y+1][x+1]
                       - gray[y-1][x-1] - 2 * gray[y-1][x] - gray[y-1][x+1];
                    mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
                    if (mag > 255) begin
                        mag = 255;
                    end
                end
                on = (mag >= int'(HIGH_THRESHOLD)) ||
                     ((mag >= int'(LOW_THRESHOLD)) && prev_on && (x != 0));
                edges[y * IMAGE_WIDTH + x] = on ? EDGE_ON : EDGE_OFF;
                count = count + int'(on);
                prev_on = on;
            end
        end
        return count;
    endfunction

    // Flat, step, ramp, then random frames, plus the output stall pattern
    task automatic build_frames();
        int g;
        int step_col;
        edge_frame_t edges;
        for (int f = 0; f < FRAME_COUNT; f++) begin
            for (int i = 0; i < FRAME_PIXELS; i++) begin
                case (f)
                    0: frames[f][i] = 24'h808080;
                    1: frames[f][i] = (i % IMAGE_WIDTH < IMAGE_WIDTH / 2) ? 24'h000000 : 24'hffffff;
                    2: begin
                        // Weak slope with one steep step that moves right row by row
                        step_col = 4 + 3 * ((i / IMAGE_WIDTH) % 3);
                        g = 10 * (i % IMAGE_WIDTH) + ((i % IMAGE_WIDTH >= step_col) ? 30 : 0);
                        frames[f][i] = {3{PIXEL_BITS'(g)}};
                    end
                    default: frames[f][i] = RGB_BITS'($random(seed));
                endcase
            end
            exp_counts.push_back(reference_edges(frames[f], edges));
            for (int i = 0; i < FRAME_PIXELS; i++) begin
                exp_pixels.push_back(edges[i]);
            end
        end
        for (int s = 0; s < STRETCHES; s++) begin
            hold_len[s] = 100 + int'($unsigned($random(seed)) % 100);
            run_len[s]  = 16 + int'($unsigned($random(seed)) % 16);
        end
    endtask

    task automatic send_frames();
        int i;
        for (int f = 0; f < FRAME_COUNT; f++) begin
            i = 0;
            while (i < FRAME_PIXELS) begin
                @(posedge clock);
                #1;
                if (image_full) begin
                    image_wr_en = 1'b0;
                    if (pixels_read >= PRESSURE_START) begin
                        saw_full = 1'b1;
                    end
                end else begin
                    image_wr_en = 1'b1;
                    image_din = frames[f][i];
                    i++;
                end
            end
        end
        @(posedge clock);
        #1;
        image_wr_en = 1'b0;
    endtask

    task automatic collect_outputs();
        int hold_left;
        int run_left;
        int stretch;
        int expected_count;
        logic [PIXEL_BITS-1:0] expected;
        hold_left = 0;
        run_left = 1;
        stretch = 0;
        while (pixels_read < TOTAL_PIXELS || frames_seen < FRAME_COUNT) begin
            @(posedge clock);
            #1;
            if (frame_done) begin
                assert (exp_counts.size() > 0) else begin
                    error_count++;
                    $display("frame_done pulsed at %0t ns with no frame outstanding", $time);
                end
                if (exp_counts.size() > 0) begin
                    expected_count = exp_counts.pop_front();
                    assert (int'(edge_count) == expected_count) else begin
                        error_count++;
                        $display("** Error at %0t ns: frame %0d edge_count %0d, expected %0d",
                                 $time, frames_seen, edge_count, expected_count);
                    end
                    frames_seen++;
                end
            end
            if (hold_left > 0) begin
                hold_left--;
                out_rd_en = 1'b0;
            end else if (!out_empty && pixels_read < TOTAL_PIXELS) begin
                expected = exp_pixels.pop_front();
                assert (out_dout == expected) else begin
                    error_count++;
                    $display("** Error at %0t ns: frame %0d pixel %0d is %0d, expected %0d",
                             $time, pixels_read / FRAME_PIXELS, pixels_read % FRAME_PIXELS,
                             out_dout, expected);
                end
                out_rd_en = 1'b1;
                pixels_read++;
                if (pixels_read > PRESSURE_START) begin
                    run_left--;
                    if (run_left == 0) begin
                        hold_left = hold_len[stretch % STRETCHES];
                        stretch++;
                        run_left = run_len[stretch % STRETCHES];
                    end
                end
            end else begin
                out_rd_en = 1'b0;
            end
        end
        @(posedge clock);
        #1;
        out_rd_en = 1'b0;
        assert (out_empty) else begin
            error_count++;
            $display("The output FIFO still holds pixels after the last frame");
        end
    endtask

    task automatic print_summary();
        $display("Summary: %0d pixels checked, %0d frames checked, %0d errors",
                 pixels_read, frames_seen, error_count);
    endtask

    initial begin
        reset = 1'b1;
        image_wr_en = 1'b0;
        image_din = '0;
        out_rd_en = 1'b0;
        build_frames();
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        assert (out_empty && !image_full && !frame_done && edge_count == 16'd0) else begin
            error_count++;
            $display("** Error at %0t ns: outputs not in their reset state", $time);
        end
        fork
            send_frames();
            collect_outputs();
        join
        assert (saw_full) else begin
            error_count++;
            $display("image_full never rose while the output was stalled");
        end
        print_summary();
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        print_summary();
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/edge_pkg.sv
`default_nettype none

package edge_pkg;

    // Word widths
    localparam int RGB_BITS   = 24;
    localparam int PIXEL_BITS = 8;

    // Channel positions inside an RGB word
    localparam int RED_LSB   = 16;
    localparam int GREEN_LSB = 8;
    localparam int BLUE_LSB  = 0;

    // Gradient levels for weak and strong edges
    localparam logic [PIXEL_BITS-1:0] LOW_THRESHOLD  = 8'd60;
    localparam logic [PIXEL_BITS-1:0] HIGH_THRESHOLD = 8'd120;

    // Values written to the edge map
    localparam logic [PIXEL_BITS-1:0] EDGE_ON  = 8'd255;
    localparam logic [PIXEL_BITS-1:0] EDGE_OFF = 8'd0;

endpackage

`default_nettype wire

//--- verilog/edge_threshold.sv
`timescale 1ns/1ps
`default_nettype none

module edge_threshold
    import edge_pkg::*;
#(
    parameter int IMAGE_WIDTH  = 16,
    parameter int IMAGE_HEIGHT = 8
) (
    input  logic                    clock,
    input  logic                    reset,
    output logic                    in_rd_en,
    input  logic                    in_empty,
    input  logic [PIXEL_BITS-1:0]   in_dout,
    output logic                    out_wr_en,
    input  logic                    out_full,
    output logic [PIXEL_BITS-1:0]   out_din,
    output logic                    frame_done,
    output logic [15:0]             edge_count
);

    localparam int COL_BITS = $clog2(IMAGE_WIDTH);
    localparam int PIX_BITS = $clog2(IMAGE_WIDTH * IMAGE_HEIGHT);
    localparam logic [COL_BITS-1:0] LAST_COL   = COL_BITS'(IMAGE_WIDTH - 1);
    localparam logic [PIX_BITS-1:0] LAST_PIXEL = PIX_BITS'(IMAGE_WIDTH * IMAGE_HEIGHT - 1);

    logic [COL_BITS-1:0]    col;
    logic [PIX_BITS-1:0]    pixel;
    logic                   out_valid;
    logic                   out_last;
    logic                   prev_on;
    logic                   edge_on;
    logic [15:0]            running_count;

    assign out_wr_en = out_valid && !out_full;
    assign in_rd_en  = !in_empty && (!out_valid || out_wr_en);

    // Weak pixels survive only next to an edge on their left
    assign edge_on = (in_dout >= HIGH_THRESHOLD) ||
                     ((in_dout >= LOW_THRESHOLD) && prev_on && (col != '0));

    always_ff @(posedge clock) begin
        if (reset) begin
            col           <= '0;
            pixel         <= '0;
            out_valid     <= 1'b0;
            out_last      <= 1'b0;
            prev_on       <= 1'b0;
            running_count <= '0;
            frame_done    <= 1'b0;
            edge_count    <= '0;
        end else begin
            if (in_rd_en) begin
                out_valid <= 1'b1;
                out_last  <= (pixel == LAST_PIXEL);
                prev_on   <= edge_on;
                col       <= (col == LAST_COL) ? '0 : col + 1'b1;
                pixel     <= (pixel == LAST_PIXEL) ? '0 : pixel + 1'b1;
            end else if (out_wr_en) begin
                out_valid <= 1'b0;
            end

            // Count edges as they leave and publish the total at frame end
            if (out_wr_en && out_last) begin
                running_count <= '0;
                edge_count    <= running_count + 16'(out_din == EDGE_ON);
            end else if (out_wr_en && (out_din == EDGE_ON)) begin
                running_count <= running_count + 1'b1;
            end
            frame_done <= out_wr_en && out_last;
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            out_din <= edge_on ? EDGE_ON : EDGE_OFF;
        end
    end

endmodule

`default_nettype wire

//--- verilog/edge_top.sv
`timescale 1ns/1ps
`default_nettype none

module edge_top
    import edge_pkg::*;
#(
    parameter int IMAGE_WIDTH  = 16,
    parameter int IMAGE_HEIGHT = 8,
    parameter int FIFO_DEPTH   = 16
) (
    input  logic                    clock,
    input  logic                    reset,
    // Pixel input
    input  logic                    image_wr_en,
    input  logic [RGB_BITS-1:0]     image_din,
    output logic                    image_full,
    // Edge map output
    input  logic                    out_rd_en,
    output logic [PIXEL_BITS-1:0]   out_dout,
    output logic                    out_empty,
    // Frame status
    output logic                    frame_done,
    output logic [15:0]             edge_count
);

    // Input FIFO to grayscale
    logic                   image_rd_en;
    logic                   image_empty;
    logic [RGB_BITS-1:0]    image_dout;

    // Grayscale through the gray FIFO to sobel
    logic                   gray_wr_en;
    logic                   gray_full;
    logic [PIXEL_BITS-1:0]  gray_din;
    logic                   gray_rd_en;
    logic                   gray_empty;
    logic [PIXEL_BITS-1:0]  gray_dout;

    // Sobel through the magnitude FIFO to thresholding
    logic                   mag_wr_en;
    logic                   mag_full;
    logic [PIXEL_BITS-1:0]  mag_din;
    logic                   mag_rd_en;
    logic                   mag_empty;
    logic [PIXEL_BITS-1:0]  mag_dout;

    // Thresholding to the output FIFO
    logic                   edge_wr_en;
    logic                   edge_full;
    logic [PIXEL_BITS-1:0]  edge_din;

    fifo #(
        .DATA_WIDTH(RGB_BITS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo_image_inst (
        .clock(clock),
        .reset(reset),
        .wr_en(image_wr_en),
        .din(image_din),
        .full(image_full),
        .rd_en(image_rd_en),
        .dout(image_dout),
        .empty(image_empty)
    );

    grayscale grayscale_inst (
        .clock(clock),
        .reset(reset),
        .in_rd_en(image_rd_en),
        .in_empty(image_empty),
        .in_dout(image_dout),
        .out_wr_en(gray_wr_en),
        .out_full(gray_full),
        .out_din(gray_din)
    );

    fifo #(
        .DATA_WIDTH(PIXEL_BITS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo_gray_inst (
        .clock(clock),
        .reset(reset),
        .wr_en(gray_wr_en),
        .din(gray_din),
        .full(gray_full),
        .rd_en(gray_rd_en),
        .dout(gray_dout),
        .empty(gray_empty)
    );

    sobel #(
        .IMAGE_WIDTH(IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT)
    ) sobel_inst (
        .clock(clock),
        .reset(reset),
        .in_rd_en(gray_rd_en),
        .in_empty(gray_empty),
        .in_dout(gray_dout),
        .out_wr_en(mag_wr_en),
        .out_full(mag_full),
        .out_din(mag_din)
    );

    fifo #(
        .DATA_WIDTH(PIXEL_BITS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo_magnitude_inst (
        .clock(clock),
        .reset(reset),
        .wr_en(mag_wr_en),
        .din(mag_din),
        .full(mag_full),
        .rd_en(mag_rd_en),
        .dout(mag_dout),
        .empty(mag_empty)
    );

    edge_threshold #(
        .IMAGE_WIDTH(IMAGE_WIDTH),
        .IMAGE_HEIGHT(IMAGE_HEIGHT)
    ) edge_threshold_inst (
        .clock(clock),
        .reset(reset),
        .in_rd_en(mag_rd_en),
        .in_empty(mag_empty),
        .in_dout(mag_dout),
        .out_wr_en(edge_wr_en),
        .out_full(edge_full),
        .out_din(edge_din),
        .frame_done(frame_done),
        .edge_count(edge_count)
    );

    fifo #(
        .DATA_WIDTH(PIXEL_BITS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo_out_inst (
        .clock(clock),
        .reset(reset),
        .wr_en(edge_wr_en),
        .din(edge_din),
        .full(edge_full),
        .rd_en(out_rd_en),
        .dout(out_dout),
        .empty(out_empty)
    );

endmodule

`default_nettype wire

//--- verilog/fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    wr_en,
    input  logic [DATA_WIDTH-1:0]   din,
    output logic                    full,
    input  logic                    rd_en,
    output logic [DATA_WIDTH-1:0]   dout,
    output logic                    empty
);

    localparam int ADDR_BITS = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

    // Extra top bit tells a full buffer from an empty one
    logic [ADDR_BITS:0] wr_ptr;
    logic [ADDR_BITS:0] rd_ptr;

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_BITS-1:0]] <= din;
        end
    end

    // Show-ahead output with the head entry always on dout
    assign dout  = mem[rd_ptr[ADDR_BITS-1:0]];
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_BITS] != rd_ptr[ADDR_BITS]) &&
                   (wr_ptr[ADDR_BITS-1:0] == rd_ptr[ADDR_BITS-1:0]);

    // Producers and consumers must honour the status flags
    assert property (@(posedge clock) disable iff (reset) wr_en |-> !full)
        else $error("fifo written while full");

    assert property (@(posedge clock) disable iff (reset) rd_en |-> !empty)
        else $error("fifo read while empty");

endmodule

`default_nettype wire

//--- verilog/grayscale.sv
`timescale 1ns/1ps
`default_nettype none

module grayscale
    import edge_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    output logic                    in_rd_en,
    input  logic                    in_empty,
    input  logic [RGB_BITS-1:0]     in_dout,
    output logic                    out_wr_en,
    input  logic                    out_full,
    output logic [PIXEL_BITS-1:0]   out_din
);

    logic       gray_valid;
    logic [9:0] rgb_sum;

    assign rgb_sum = 10'(in_dout[RED_LSB +: PIXEL_BITS]) +
                     10'(in_dout[GREEN_LSB +: PIXEL_BITS]) +
                     10'(in_dout[BLUE_LSB +: PIXEL_BITS]);

    // One-entry output register that is refilled as it drains
    assign out_wr_en = gray_valid && !out_full;
    assign in_rd_en  = !in_empty && (!gray_valid || out_wr_en);

    always_ff @(posedge clock) begin
        if (reset) begin
            gray_valid <= 1'b0;
        end else if (in_rd_en) begin
            gray_valid <= 1'b1;
        end else if (out_wr_en) begin
            gray_valid <= 1'b0;
        end
    end

    // Truncated mean of the three channels
    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            out_din <= PIXEL_BITS'(rgb_sum / 10'd3);
        end
    end

endmodule

`default_nettype wire

//--- verilog/sobel.sv
`timescale 1ns/1ps
`default_nettype none

module sobel
    import edge_pkg::*;
#(
    parameter int IMAGE_WIDTH  = 16,
    parameter int IMAGE_HEIGHT = 8
) (
    input  logic                    clock,
    input  logic                    reset,
    output logic                    in_rd_en,
    input  logic                    in_empty,
    input  logic [PIXEL_BITS-1:0]   in_dout,
    output logic                    out_wr_en,
    input  logic                    out_full,
    output logic [PIXEL_BITS-1:0]   out_din
);

    localparam int COL_BITS = $clog2(IMAGE_WIDTH);
    localparam int ROW_BITS = $clog2(IMAGE_HEIGHT);
    localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(IMAGE_WIDTH - 1);
    localparam logic [ROW_BITS-1:0] LAST_ROW = ROW_BITS'(IMAGE_HEIGHT - 1);

    // Previous row and the one before it
    logic [PIXEL_BITS-1:0] line_prev  [IMAGE_WIDTH];
    logic [PIXEL_BITS-1:0] line_prev2 [IMAGE_WIDTH];

    // Window rows go top to bottom and column 2 holds the newest pixel
    logic [PIXEL_BITS-1:0] win [3][3];

    logic [COL_BITS-1:0] in_col;
    logic [ROW_BITS-1:0] in_row;
    logic [COL_BITS-1:0] out_col;
    logic [ROW_BITS-1:0] out_row;

    logic flushing;
    logic pending;
    logic pending_border;
    logic can_step;
    logic out_due;
    logic in_last;
    logic out_last;
    logic issue;

    logic [10:0]            gx_pos;
    logic [10:0]            gx_neg;
    logic [10:0]            gy_pos;
    logic [10:0]            gy_neg;
    logic [10:0]            gx_abs;
    logic [10:0]            gy_abs;
    logic [10:0]            mag_sum;
    logic [PIXEL_BITS-1:0]  magnitude;

    // A new step is allowed once the pending result leaves
    assign can_step  = !pending || out_wr_en;
    assign in_rd_en  = !in_empty && !flushing && can_step;
    assign out_wr_en = pending && !out_full;

    // Outputs trail the input by one row plus one pixel
    assign out_due  = (in_row > ROW_BITS'(1)) || ((in_row == ROW_BITS'(1)) && (in_col != '0));
    assign in_last  = (in_row == LAST_ROW) && (in_col == LAST_COL);
    assign out_last = (out_row == LAST_ROW) && (out_col == LAST_COL);
    assign issue    = (in_rd_en && out_due) || (flushing && can_step);

    always_ff @(posedge clock) begin
        if (reset) begin
            in_col   <= '0;
            in_row   <= '0;
            out_col  <= '0;
            out_row  <= '0;
            flushing <= 1'b0;
            pending  <= 1'b0;
        end else begin
            if (in_rd_en) begin
                if (in_col == LAST_COL) begin
                    in_col <= '0;
                    in_row <= (in_row == LAST_ROW) ? '0 : in_row + 1'b1;
                end else begin
                    in_col <= in_col + 1'b1;
                end
            end

            // Remaining outputs after the last pixel are issued without reads
            if (in_rd_en && in_last) begin
                flushing <= 1'b1;
            end else if (issue && out_last) begin
                flushing <= 1'b0;
            end

            if (issue) begin
                pending <= 1'b1;
                if (out_col == LAST_COL) begin
                    out_col <= '0;
                    out_row <= out_last ? '0 : out_row + 1'b1;
                end else begin
                    out_col <= out_col + 1'b1;
                end
            end else if (out_wr_en) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            for (int r = 0; r < 3; r++) begin
                win[r][0] <= win[r][1];
                win[r][1] <= win[r][2];
            end
            win[0][2] <= line_prev2[in_col];
            win[1][2] <= line_prev[in_col];
            win[2][2] <= in_dout;
            line_prev2[in_col] <= line_prev[in_col];
            line_prev[in_col]  <= in_dout;
        end
        if (issue) begin
            pending_border <= (out_row == '0) || (out_row == LAST_ROW) ||
                              (out_col == '0) || (out_col == LAST_COL);
        end
    end

    // Standard kernels split into positive and negative taps
    always_comb begin
        gx_pos = 11'(win[0][2]) + (11'(win[1][2]) << 1) + 11'(win[2][2]);
        gx_neg = 11'(win[0][0]) + (11'(win[1][0]) << 1) + 11'(win[2][0]);
        gy_pos = 11'(win[2][0]) + (11'(win[2][1]) << 1) + 11'(win[2][2]);
        gy_neg = 11'(win[0][0]) + (11'(win[0][1]) << 1) + 11'(win[0][2]);
        gx_abs = (gx_pos >= gx_neg) ? gx_pos - gx_neg : gx_neg - gx_pos;
        gy_abs = (gy_pos >= gy_neg) ? gy_pos - gy_neg : gy_neg - gy_pos;
        mag_sum = gx_abs + gy_abs;
        magnitude = (mag_sum > 11'd255) ? 8'd255 : mag_sum[PIXEL_BITS-1:0];
    end

    // Frame borders have no full neighbourhood
    assign out_din = pending_border ? '0 : magnitude;

    // The last output of a frame comes only after the whole frame was read
    assert property (@(posedge clock) disable iff (reset)
        (issue && out_last) |-> (flushing && (in_row == '0) && (in_col == '0)))
        else $error("sobel output count ran ahead of the frame");

endmodule

`default_nettype wire
